// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0] u32_t;

    // one direct-mapped window as held in a DMW CSR
    typedef struct packed {
        logic       plv0;   // window usable at privilege level 0
        logic       plv3;   // window usable at privilege level 3
        logic [1:0] mat;
        logic [2:0] pseg;   // replaces va[31:29] on a hit
        logic [2:0] vseg;   // compared against va[31:29]
    } dmw_t;

    // the slice of CSR state that instruction fetch looks at
    typedef struct packed {
        logic [1:0] crmd_plv;
        logic       da;
        logic       pg;
        logic [1:0] datm;   // memory type used in direct-address mode
        dmw_t       dmw0;
        dmw_t       dmw1;
    } csr_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
        logic is_predict;
    } redirect_t;

    typedef struct packed {
        logic valid;
        u32_t npc;
    } btb_predict_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
        u32_t target;
    } btb_update_t;

    typedef struct packed {
        logic        req;
        logic [11:0] idx;   // virtual index, the cache is VIPT
        u32_t        pa;
        logic        is_cached;
    } icache_req_t;

    typedef struct packed {
        u32_t pc;
        logic is_predict;
    } next_pc_t;

    typedef struct packed {
        logic     valid;
        u32_t     pc;
        logic     wait_resp;    // fetch stage 2 must wait for the cache data
        next_pc_t next;
    } fetch_pass_t;

    // LoongArch ecode values
    typedef enum logic [5:0] {
        EXC_NONE = 6'h00,
        EXC_ADEF = 6'h08,
        EXC_TLBR = 6'h3f
    } excp_code_t;

    typedef struct packed {
        logic       valid;
        excp_code_t code;
        u32_t       badv;
    } excp_pass_t;

    parameter u32_t RESET_PC_DEFAULT    = 32'h1c00_0000;
    parameter int   BTB_ENTRIES_DEFAULT = 64;  // must stay a power of two

endpackage

// ==== source/next_pc_select.sv ====
`timescale 1ns/1ns

module next_pc_select (
    input  fetch_pkg::u32_t         pc_i,
    input  fetch_pkg::redirect_t    redirect_excp_i,
    input  fetch_pkg::redirect_t    redirect_mem_i,
    input  fetch_pkg::redirect_t    redirect_if2_i,
    input  fetch_pkg::btb_predict_t predict_i,
    output fetch_pkg::next_pc_t     next_o
);

    // later pipeline stages know more, so they win over earlier guesses
    always_comb begin
        if (redirect_excp_i.valid) begin
            next_o.pc         = redirect_excp_i.pc;
            next_o.is_predict = 1'b0;
        end else if (redirect_mem_i.valid) begin
            next_o.pc         = redirect_mem_i.pc;  // resolved branch, not a guess
            next_o.is_predict = 1'b0;
        end else if (redirect_if2_i.valid) begin
            next_o.pc         = redirect_if2_i.pc;
            next_o.is_predict = redirect_if2_i.is_predict;
        end else if (predict_i.valid) begin
            // prediction was looked up for the pc now in the register
            next_o.pc         = predict_i.npc;
            next_o.is_predict = 1'b1;
        end else begin
            next_o.pc         = pc_i + 32'd4;
            next_o.is_predict = 1'b1;   // fall-through is still a prediction
        end
    end

endmodule

// ==== source/branch_target_buffer.sv ====
`timescale 1ns/1ns

module branch_target_buffer #(
    parameter int BTB_ENTRIES = fetch_pkg::BTB_ENTRIES_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::u32_t         lookup_pc_i,
    input  logic                    stall_i,
    input  fetch_pkg::btb_update_t  update_i,
    output fetch_pkg::btb_predict_t predict_o
);

    import fetch_pkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;      // pc[1:0] are always zero for fetch

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q [BTB_ENTRIES];
    u32_t                   target_q [BTB_ENTRIES];

    logic [IDX_W-1:0] lkp_idx;
    logic [TAG_W-1:0] lkp_tag;
    logic [IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0] upd_tag;

    logic hit_q;
    u32_t npc_q;

    assign lkp_idx = lookup_pc_i[IDX_W+1:2];
    assign lkp_tag = lookup_pc_i[31:IDX_W+2];
    assign upd_idx = update_i.pc[IDX_W+1:2];
    assign upd_tag = update_i.pc[31:IDX_W+2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // a newer update simply overwrites whatever held this index
    always_ff @(posedge clk) begin
        if (update_i.valid) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= update_i.target;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
        end else if (!stall_i) begin
            hit_q <= valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            npc_q <= target_q[lkp_idx];
        end
    end

    assign predict_o.valid = hit_q;
    assign predict_o.npc   = npc_q;

endmodule

// ==== source/fetch_addr_translate.sv ====
`timescale 1ns/1ns

module fetch_addr_translate (
    input  fetch_pkg::u32_t       va_i,
    input  fetch_pkg::csr_t       csr_i,
    output fetch_pkg::u32_t       pa_o,
    output logic [1:0]            mat_o,
    output fetch_pkg::excp_pass_t excp_o
);

    import fetch_pkg::*;

    logic paged;
    logic hit0;
    logic hit1;

    function automatic logic dmw_hit(input dmw_t dmw, input logic [1:0] plv,
                                     input logic [2:0] vtop);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && dmw.plv0) || (plv == 2'd3 && dmw.plv3);
        return plv_ok && (dmw.vseg == vtop);
    endfunction

    // da wins if software ever sets both mode bits
    assign paged = csr_i.pg & ~csr_i.da;
    assign hit0  = dmw_hit(csr_i.dmw0, csr_i.crmd_plv, va_i[31:29]);
    assign hit1  = dmw_hit(csr_i.dmw1, csr_i.crmd_plv, va_i[31:29]);

    always_comb begin
        pa_o  = va_i;
        mat_o = csr_i.datm;
        if (paged) begin
            if (hit0) begin
                pa_o[31:29] = csr_i.dmw0.pseg;
                mat_o       = csr_i.dmw0.mat;
            end else if (hit1) begin
                pa_o[31:29] = csr_i.dmw1.pseg;
                mat_o       = csr_i.dmw1.mat;
            end else begin
                mat_o = 2'b00;  // no request goes out on a miss anyway
            end
        end
    end

    always_comb begin
        excp_o.valid = 1'b0;
        excp_o.code  = EXC_NONE;
        excp_o.badv  = va_i;
        if (va_i[1:0] != 2'b00) begin
            excp_o.valid = 1'b1;
            excp_o.code  = EXC_ADEF;
        end else if (paged && !hit0 && !hit1) begin
            // without a TLB every paged miss goes to the refill handler
            excp_o.valid = 1'b1;
            excp_o.code  = EXC_TLBR;
        end
    end

endmodule

// ==== source/fetch1_stage.sv ====
`timescale 1ns/1ns

module fetch1_stage #(
    parameter fetch_pkg::u32_t RESET_PC = fetch_pkg::RESET_PC_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::csr_t         csr_i,
    input  fetch_pkg::redirect_t    redirect_excp_i,
    input  fetch_pkg::redirect_t    redirect_mem_i,
    input  fetch_pkg::redirect_t    redirect_if2_i,
    input  fetch_pkg::btb_predict_t btb_predict_i,
    input  logic                    icache_ready_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    output fetch_pkg::u32_t         btb_pc_o,
    output logic                    btb_stall_o,
    output fetch_pkg::icache_req_t  icache_req_o,
    output logic                    stall_o,
    output fetch_pkg::fetch_pass_t  fetch_o,
    output fetch_pkg::excp_pass_t   excp_o
);

    import fetch_pkg::*;

    u32_t       pc_q;
    next_pc_t   next;
    u32_t       pa;
    logic [1:0] mat;
    excp_pass_t addr_excp;
    logic       req_pending;    // a cache request is out for pc_q
    logic       pc_load;
    logic       fetch_valid;

    next_pc_select u_npc (
        .pc_i            (pc_q),
        .redirect_excp_i (redirect_excp_i),
        .redirect_mem_i  (redirect_mem_i),
        .redirect_if2_i  (redirect_if2_i),
        .predict_i       (btb_predict_i),
        .next_o          (next)
    );

    fetch_addr_translate u_trans (
        .va_i   (pc_q),
        .csr_i  (csr_i),
        .pa_o   (pa),
        .mat_o  (mat),
        .excp_o (addr_excp)
    );

    assign req_pending = ~addr_excp.valid;
    assign stall_o     = stall_i | (req_pending & ~icache_ready_i);
    assign pc_load     = ~stall_o | flush_i;    // a flush must not wait for the cache
    assign fetch_valid = ~stall_o & ~flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (pc_load) begin
            pc_q <= next.pc;
        end
    end

    // BTB registers together with the PC so its output always matches pc_q
    assign btb_pc_o    = next.pc;
    assign btb_stall_o = ~pc_load;

    assign icache_req_o.req       = req_pending;
    assign icache_req_o.idx       = pc_q[11:0];
    assign icache_req_o.pa        = pa;
    assign icache_req_o.is_cached = mat[0];

    assign fetch_o.valid     = fetch_valid;
    assign fetch_o.pc        = pc_q;
    assign fetch_o.wait_resp = req_pending;
    assign fetch_o.next      = next;

    always_comb begin
        excp_o       = addr_excp;
        excp_o.valid = addr_excp.valid & fetch_valid;
    end

endmodule

// ==== source/fetch_frontend_top.sv ====
`timescale 1ns/1ns

module fetch_frontend_top #(
    parameter fetch_pkg::u32_t RESET_PC    = fetch_pkg::RESET_PC_DEFAULT,
    parameter int              BTB_ENTRIES = fetch_pkg::BTB_ENTRIES_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fetch_pkg::csr_t        csr_i,
    input  fetch_pkg::redirect_t   redirect_excp_i,
    input  fetch_pkg::redirect_t   redirect_mem_i,
    input  fetch_pkg::redirect_t   redirect_if2_i,
    input  fetch_pkg::btb_update_t btb_update_i,
    input  logic                   icache_ready_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    output fetch_pkg::icache_req_t icache_req_o,
    output logic                   stall_o,
    output fetch_pkg::fetch_pass_t fetch_o,
    output fetch_pkg::excp_pass_t  excp_o
);

    import fetch_pkg::*;

    u32_t         btb_pc;
    logic         btb_stall;
    btb_predict_t btb_predict;

    fetch1_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch1 (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr_i           (csr_i),
        .redirect_excp_i (redirect_excp_i),
        .redirect_mem_i  (redirect_mem_i),
        .redirect_if2_i  (redirect_if2_i),
        .btb_predict_i   (btb_predict),
        .icache_ready_i  (icache_ready_i),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .btb_pc_o        (btb_pc),
        .btb_stall_o     (btb_stall),
        .icache_req_o    (icache_req_o),
        .stall_o         (stall_o),
        .fetch_o         (fetch_o),
        .excp_o          (excp_o)
    );

    branch_target_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_pc_i (btb_pc),
        .stall_i     (btb_stall),
        .update_i    (btb_update_i),
        .predict_o   (btb_predict)
    );

endmodule

// ==== verif/fetch_tb_assertions.sv ====
`timescale 1ns/1ns

module fetch_tb_assertions (
    input logic            clk,
    input logic            rst_n,
    input fetch_pkg::u32_t pc_i,
    input logic            stall_i,
    input logic            flush_i,
    input logic            fetch_valid_i,
    input logic            req_i,
    input logic            excp_valid_i
);

    // a stall without a flush freezes the PC register
    pc_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i && !flush_i |=> $stable(pc_i))
        else $error("pc changed while the stage was stalled");

    no_valid_on_flush_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_valid_i && flush_i))
        else $error("fetch valid together with flush");

    // a faulting or misaligned pc must never reach the cache
    no_req_on_excp_a: assert property (@(posedge clk) disable iff (!rst_n)
        req_i |-> !excp_valid_i && pc_i[1:0] == 2'b00)
        else $error("cache request issued for a pc with an exception");

endmodule

bind fetch1_stage fetch_tb_assertions u_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_i          (pc_q),
    .stall_i       (stall_o),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_o.valid),
    .req_i         (icache_req_o.req),
    .excp_valid_i  (excp_o.valid)
);

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

    import fetch_pkg::*;

    localparam int BTB_N = BTB_ENTRIES_DEFAULT;

    typedef logic [$clog2(BTB_N)-1:0] btb_idx_t;

    typedef struct {
        int          test;
        csr_t        csr;
        redirect_t   rex;
        redirect_t   rmem;
        redirect_t   rif2;
        btb_update_t upd;
        logic        ready;
        logic        stall;
        logic        flush;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    csr_t        csr;
    redirect_t   redirect_excp;
    redirect_t   redirect_mem;
    redirect_t   redirect_if2;
    btb_update_t btb_update;
    logic        icache_ready;
    logic        stall_in;
    logic        flush;
    icache_req_t icache_req;
    logic        stall_out;
    fetch_pass_t fetch;
    excp_pass_t  excp;

    // reference model state with its own pc and BTB copy
    u32_t        m_pc;
    logic        m_hit;
    u32_t        m_npc;
    logic        m_valid [BTB_N];
    u32_t        m_tag [BTB_N];
    u32_t        m_target [BTB_N];
    next_pc_t    m_next;
    logic        m_load;
    fetch_pass_t exp_fetch;
    icache_req_t exp_icache;
    excp_pass_t  exp_excp;
    logic        exp_stall;

    row_t  rows[$];
    int    errors = 0;
    int    checks = 0;
    int    test_errors = 0;
    string names[6] = '{"", "reset and sequential fetch", "redirect priority",
                        "btb prediction", "stall and flush", "paged translation"};

    always #2 clk = ~clk;

    fetch_frontend_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr_i           (csr),
        .redirect_excp_i (redirect_excp),
        .redirect_mem_i  (redirect_mem),
        .redirect_if2_i  (redirect_if2),
        .btb_update_i    (btb_update),
        .icache_ready_i  (icache_ready),
        .stall_i         (stall_in),
        .flush_i         (flush),
        .icache_req_o    (icache_req),
        .stall_o         (stall_out),
        .fetch_o         (fetch),
        .excp_o          (excp)
    );

    function automatic row_t idle_row(input int test, input csr_t c);
        row_t r;
        r = '{test: test, csr: c, rex: '0, rmem: '0, rif2: '0, upd: '0,
              ready: 1'b1, stall: 1'b0, flush: 1'b0};
        return r;
    endfunction

    function automatic btb_idx_t btb_index(input u32_t pc);
        return btb_idx_t'((pc >> 2) % BTB_N);
    endfunction

    function automatic u32_t btb_tag(input u32_t pc);
        return pc / (BTB_N * 4);
    endfunction

    function automatic logic window_match(input dmw_t w, input logic [1:0] plv, input u32_t va);
        return w.vseg == va[31:29] && ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3));
    endfunction

    task automatic compute_expected(input row_t r);
        u32_t       pa;
        logic [1:0] mat;
        excp_code_t code;
        logic       exc;
        pa   = m_pc;
        mat  = r.csr.datm;
        code = EXC_NONE;
        if (r.csr.pg && !r.csr.da) begin
            if (window_match(r.csr.dmw0, r.csr.crmd_plv, m_pc)) begin
                pa  = {r.csr.dmw0.pseg, m_pc[28:0]};
                mat = r.csr.dmw0.mat;
            end else if (window_match(r.csr.dmw1, r.csr.crmd_plv, m_pc)) begin
                pa  = {r.csr.dmw1.pseg, m_pc[28:0]};
                mat = r.csr.dmw1.mat;
            end else begin
                code = EXC_TLBR;
            end
        end
        if (m_pc[1:0] != 2'b00) code = EXC_ADEF;   // alignment beats the window miss
        exc = (code != EXC_NONE);
        exp_stall = r.stall || (!exc && !r.ready);
        if (r.rex.valid) m_next = '{r.rex.pc, 1'b0};
        else if (r.rmem.valid) m_next = '{r.rmem.pc, 1'b0};
        else if (r.rif2.valid) m_next = '{r.rif2.pc, r.rif2.is_predict};
        else if (m_hit) m_next = '{m_npc, 1'b1};
        else m_next = '{m_pc + 32'd4, 1'b1};
        exp_fetch  = '{!exp_stall && !r.flush, m_pc, !exc, m_next};
        exp_icache = '{!exc, m_pc[11:0], pa, mat[0]};
        exp_excp   = '{exc && exp_fetch.valid, code, m_pc};
        m_load     = !exp_stall || r.flush;
    endtask

    task automatic advance_model(input row_t r);
        btb_idx_t i;
        i = btb_index(m_next.pc);
        if (m_load) begin
            // lookup sees the table as it was before this edge's update
            m_hit = m_valid[i] && m_tag[i] == btb_tag(m_next.pc);
            m_npc = m_target[i];
            m_pc  = m_next.pc;
        end
        if (r.upd.valid) begin
            i = btb_index(r.upd.pc);
            m_valid[i]  = 1'b1;
            m_tag[i]    = btb_tag(r.upd.pc);
            m_target[i] = r.upd.target;
        end
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_fetch(input fetch_pass_t exp, input fetch_pass_t act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] fetch_o exp %h got %h", exp, act);
            note_error();
        end
    endtask

    task automatic check_icache(input icache_req_t exp, input icache_req_t act);
        checks++;
        if (act.req !== exp.req || (exp.req && act !== exp)) begin
            $display("[ERROR] icache_req_o exp %h got %h", exp, act);
            note_error();
        end
    endtask

    task automatic check_excp(input excp_pass_t exp, input excp_pass_t act);
        checks++;
        if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
            $display("[ERROR] excp_o exp %h got %h", exp, act);
            note_error();
        end
    endtask

    task automatic check_stall(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] stall_o exp %h got %h", exp, act);
            note_error();
        end
    endtask

    task automatic drive(input row_t r);
        csr           = r.csr;
        redirect_excp = r.rex;
        redirect_mem  = r.rmem;
        redirect_if2  = r.rif2;
        btb_update    = r.upd;
        icache_ready  = r.ready;
        stall_in      = r.stall;
        flush         = r.flush;
    endtask

    task automatic wait_fetch_valid(input int max_cycles);
        int n;
        n = 0;
        #1;
        while (fetch.valid !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (fetch.valid !== 1'b1) begin
            $display("timeout: fetch_o.valid stayed low for %0d cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic build_table();
        row_t r;
        csr_t da_csr;
        csr_t pg_csr;
        u32_t p;
        da_csr      = '0;
        da_csr.da   = 1'b1;
        da_csr.datm = 2'b01;
        pg_csr      = '0;
        pg_csr.pg   = 1'b1;
        pg_csr.dmw0 = '{1'b1, 1'b0, 2'b01, 3'd0, 3'b101};  // maps 0xa... to cached 0x0...
        pg_csr.dmw1 = '{1'b1, 1'b0, 2'b00, 3'd1, 3'b100};  // maps 0x8... to uncached 0x2...
        p = 32'h1c00_0100;
        repeat (6) rows.push_back(idle_row(1, da_csr));
        r = idle_row(2, da_csr);
        r.rex  = '{1'b1, 32'h1c00_8000, 1'b1};
        r.rmem = '{1'b1, 32'h1c00_9000, 1'b1};
        r.rif2 = '{1'b1, 32'h1c00_a000, 1'b0};
        rows.push_back(r);
        r.rex = '0;
        rows.push_back(r);
        r.rmem = '0;
        rows.push_back(r);
        r.rif2 = '{1'b1, $urandom & 32'hffff_fffc, 1'b1};   // filler jump target
        rows.push_back(r);
        rows.push_back(idle_row(2, da_csr));
        r = idle_row(3, da_csr);
        r.upd = '{1'b1, p, 32'h1c00_2000};
        rows.push_back(r);
        r = idle_row(3, da_csr);
        r.rmem = '{1'b1, p, 1'b0};
        rows.push_back(r);
        repeat (2) rows.push_back(idle_row(3, da_csr));
        r = idle_row(3, da_csr);
        r.upd = '{1'b1, p + BTB_N * 4, 32'h1c00_3000};     // same index but a new tag
        rows.push_back(r);
        r = idle_row(3, da_csr);
        r.rmem = '{1'b1, p + BTB_N * 4, 1'b0};
        rows.push_back(r);
        rows.push_back(idle_row(3, da_csr));
        r.rmem = '{1'b1, p, 1'b0};
        rows.push_back(r);
        rows.push_back(idle_row(3, da_csr));
        r = idle_row(4, da_csr);
        r.ready = 1'b0;
        repeat (2) rows.push_back(r);
        repeat (6) begin
            r.ready = 1'($urandom % 2);
            rows.push_back(r);
        end
        r = idle_row(4, da_csr);
        r.stall = 1'b1;
        rows.push_back(r);
        r = idle_row(4, da_csr);
        r.ready = 1'b0;
        r.flush = 1'b1;
        r.rex   = '{1'b1, 32'h1c00_4000, 1'b0};
        rows.push_back(r);
        rows.push_back(idle_row(4, da_csr));
        // the switch to paged mode leaves the current pc outside both windows
        r = idle_row(5, pg_csr);
        r.rmem = '{1'b1, 32'ha000_1000, 1'b0};
        rows.push_back(r);
        repeat (2) rows.push_back(idle_row(5, pg_csr));
        r.rmem = '{1'b1, 32'h8000_0040, 1'b0};
        rows.push_back(r);
        rows.push_back(idle_row(5, pg_csr));
        r.rmem = '{1'b1, 32'h8000_0042, 1'b0};
        rows.push_back(r);
        repeat (2) rows.push_back(idle_row(5, pg_csr));
        r = idle_row(5, pg_csr);
        r.rex = '{1'b1, 32'ha000_0000, 1'b0};
        rows.push_back(r);
        rows.push_back(idle_row(5, pg_csr));
    endtask

    task automatic report_test(input int t);
        $display("test %0d (%s) done, %0d errors", t, names[t], test_errors);
        test_errors = 0;
    endtask

    initial begin
        row_t r;
        int   cur;
        void'($urandom(32'h704d));
        rst_n = 1'b0;
        drive(idle_row(0, '0));
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        m_pc  = RESET_PC_DEFAULT;
        m_hit = 1'b0;
        m_npc = '0;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        cur = rows[0].test;
        foreach (rows[i]) begin
            r = rows[i];
            if (r.test != cur) begin
                report_test(cur);
                cur = r.test;
            end
            drive(r);
            #1;
            compute_expected(r);
            check_stall(exp_stall, stall_out);
            check_fetch(exp_fetch, fetch);
            check_icache(exp_icache, icache_req);
            check_excp(exp_excp, excp);
            @(posedge clk);
            advance_model(r);
            @(negedge clk);
        end
        report_test(cur);
        drive(idle_row(0, r.csr));     // release everything and let fetch resume
        wait_fetch_valid(20);
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/fetch_pkg.sv
source/next_pc_select.sv
source/branch_target_buffer.sv
source/fetch_addr_translate.sv
source/fetch1_stage.sv
source/fetch_frontend_top.sv
verif/fetch_tb_assertions.sv
verif/fetch_tb.sv

// ==== Makefile ====
TOP := fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
